// File: rtl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define MIPS_WORD_W      32
`define MIPS_REG_ADDR_W  5
`define MIPS_LINK_REG    5'd31

// primary opcode, inst[31:26]
`define MIPS_OP_SPECIAL  6'b000000
`define MIPS_OP_J        6'b000010
`define MIPS_OP_JAL      6'b000011
`define MIPS_OP_BEQ      6'b000100
`define MIPS_OP_BNE      6'b000101
`define MIPS_OP_ADDIU    6'b001001
`define MIPS_OP_ANDI     6'b001100
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_XORI     6'b001110
`define MIPS_OP_LUI      6'b001111
`define MIPS_OP_LW       6'b100011
`define MIPS_OP_SW       6'b101011

// SPECIAL funct, inst[5:0]
`define MIPS_FN_SLL      6'b000000
`define MIPS_FN_SRL      6'b000010
`define MIPS_FN_SRA      6'b000011
`define MIPS_FN_JR       6'b001000
`define MIPS_FN_JALR     6'b001001
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_XOR      6'b100110
`define MIPS_FN_NOR      6'b100111
`define MIPS_FN_SLT      6'b101010
`define MIPS_FN_SLTU     6'b101011

`endif

// File: rtl/decode_pkg.sv
`default_nettype none
`include "mips_defs.svh"

package decode_pkg;

	typedef logic [`MIPS_WORD_W-1:0] word_t;
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [7:0] {
		ALU_NOP   = 8'b00000000,
		ALU_AND   = 8'b00100100,
		ALU_OR    = 8'b00100101,
		ALU_XOR   = 8'b00100110,
		ALU_NOR   = 8'b00100111,
		ALU_SLL   = 8'b01111100,
		ALU_SRL   = 8'b00000010,
		ALU_SRA   = 8'b00000011,
		ALU_SLT   = 8'b00101010,
		ALU_SLTU  = 8'b00101011,
		ALU_ADDU  = 8'b00100001,
		ALU_SUBU  = 8'b00100011,
		ALU_ADDIU = 8'b01010110,
		ALU_J     = 8'b01001111,
		ALU_JAL   = 8'b01010000,
		ALU_JR    = 8'b00001000,
		ALU_JALR  = 8'b00001001,
		ALU_BEQ   = 8'b01010001,
		ALU_BNE   = 8'b01010010,
		ALU_LW    = 8'b11100011,
		ALU_SW    = 8'b11101011
	} aluop_t;

	typedef enum logic [2:0] {
		SEL_NOP       = 3'b000,
		SEL_LOGIC     = 3'b001,
		SEL_SHIFT     = 3'b010,
		SEL_ARITH     = 3'b100,
		SEL_JUMP      = 3'b110,
		SEL_LOADSTORE = 3'b111
	} alusel_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_J,
		BR_JAL,
		BR_JR,
		BR_JALR,
		BR_BEQ,
		BR_BNE
	} branch_t;

	typedef struct packed {
		aluop_t    aluop;
		alusel_t   alusel;
		reg_addr_t wd;
		logic      wreg;
	} ctrl_t;

	// one per forwarding source
	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} bypass_t;

	localparam ctrl_t CTRL_BUBBLE = '{aluop: ALU_NOP, alusel: SEL_NOP, wd: '0, wreg: 1'b0};

endpackage

`default_nettype wire

// File: rtl/operand_if.sv
`timescale 1ns/1ns
`default_nettype none

interface operand_if
	import decode_pkg::*;
();

	logic      rd_en;  // operand comes from a register
	reg_addr_t addr;
	word_t     imm;
	word_t     value;
	logic      stall;  // load-use on this operand

	modport dec (
		output rd_en,
		output addr,
		output imm
	);

	modport fetch (
		input  rd_en,
		input  addr,
		input  imm,
		output value,
		output stall
	);

	modport user (
		input value,
		input stall
	);

endinterface

`default_nettype wire

// File: rtl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module inst_decoder
	import decode_pkg::*;
(
	input  word_t   inst_i,
	output ctrl_t   ctrl_o,
	output branch_t branch_o,
	operand_if.dec  op0_o,
	operand_if.dec  op1_o
);

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  shamt;
	logic [15:0] imm16;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	aluop_t      fn_op;
	alusel_t     fn_sel;
	logic        rd_en0;
	logic        rd_en1;
	word_t       imm;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	// R-type funct lookup
	always_comb begin
		case (funct)
			`MIPS_FN_OR:   fn_op = ALU_OR;
			`MIPS_FN_AND:  fn_op = ALU_AND;
			`MIPS_FN_XOR:  fn_op = ALU_XOR;
			`MIPS_FN_NOR:  fn_op = ALU_NOR;
			`MIPS_FN_SLL:  fn_op = ALU_SLL;
			`MIPS_FN_SRL:  fn_op = ALU_SRL;
			`MIPS_FN_SRA:  fn_op = ALU_SRA;
			`MIPS_FN_ADDU: fn_op = ALU_ADDU;
			`MIPS_FN_SUBU: fn_op = ALU_SUBU;
			`MIPS_FN_SLT:  fn_op = ALU_SLT;
			`MIPS_FN_SLTU: fn_op = ALU_SLTU;
			default:       fn_op = ALU_NOP;
		endcase
		case (funct)
			`MIPS_FN_OR, `MIPS_FN_AND, `MIPS_FN_XOR, `MIPS_FN_NOR: fn_sel = SEL_LOGIC;
			`MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA:              fn_sel = SEL_SHIFT;
			default:                                               fn_sel = SEL_ARITH;
		endcase
	end

	always_comb begin
		ctrl_o   = CTRL_BUBBLE;
		branch_o = BR_NONE;
		rd_en0   = 1'b0;
		rd_en1   = 1'b0;
		imm      = '0;
		case (opcode)
			`MIPS_OP_SPECIAL: begin
				case (funct)
					`MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA: begin
						// constant shifts, amount rides on operand 0
						if (rs == '0) begin
							ctrl_o = '{fn_op, fn_sel, rd, 1'b1};
							rd_en1 = 1'b1;
							imm    = {27'd0, shamt};
						end
					end
					`MIPS_FN_JR: begin
						ctrl_o   = '{ALU_JR, SEL_JUMP, '0, 1'b0};
						rd_en0   = 1'b1;
						branch_o = BR_JR;
					end
					`MIPS_FN_JALR: begin
						ctrl_o   = '{ALU_JALR, SEL_JUMP, rd, 1'b1};
						rd_en0   = 1'b1;
						branch_o = BR_JALR;
					end
					default: begin
						if (shamt == '0 && fn_op != ALU_NOP) begin
							ctrl_o = '{fn_op, fn_sel, rd, 1'b1};
							rd_en0 = 1'b1;
							rd_en1 = 1'b1;
						end
					end
				endcase
			end
			`MIPS_OP_ORI: begin
				ctrl_o = '{ALU_OR, SEL_LOGIC, rt, 1'b1};
				rd_en0 = 1'b1;
				imm    = {16'h0000, imm16};
			end
			`MIPS_OP_ANDI: begin
				ctrl_o = '{ALU_AND, SEL_LOGIC, rt, 1'b1};
				rd_en0 = 1'b1;
				imm    = {16'h0000, imm16};
			end
			`MIPS_OP_XORI: begin
				ctrl_o = '{ALU_XOR, SEL_LOGIC, rt, 1'b1};
				rd_en0 = 1'b1;
				imm    = {16'h0000, imm16};
			end
			`MIPS_OP_LUI: begin
				ctrl_o = '{ALU_OR, SEL_LOGIC, rt, 1'b1};  // rs is $0, or'ed with upper half
				rd_en0 = 1'b1;
				imm    = {imm16, 16'h0000};
			end
			`MIPS_OP_ADDIU: begin
				ctrl_o = '{ALU_ADDIU, SEL_ARITH, rt, 1'b1};
				rd_en0 = 1'b1;
				imm    = {{16{imm16[15]}}, imm16};
			end
			`MIPS_OP_LW: begin
				ctrl_o = '{ALU_LW, SEL_LOADSTORE, rt, 1'b1};
				rd_en0 = 1'b1;
			end
			`MIPS_OP_SW: begin
				ctrl_o = '{ALU_SW, SEL_LOADSTORE, rt, 1'b0};
				rd_en0 = 1'b1;
				rd_en1 = 1'b1;  // store data
			end
			`MIPS_OP_J: begin
				ctrl_o   = '{ALU_J, SEL_JUMP, '0, 1'b0};
				branch_o = BR_J;
			end
			`MIPS_OP_JAL: begin
				ctrl_o   = '{ALU_JAL, SEL_JUMP, `MIPS_LINK_REG, 1'b1};
				branch_o = BR_JAL;
			end
			`MIPS_OP_BEQ: begin
				ctrl_o   = '{ALU_BEQ, SEL_JUMP, '0, 1'b0};
				rd_en0   = 1'b1;
				rd_en1   = 1'b1;
				branch_o = BR_BEQ;
			end
			`MIPS_OP_BNE: begin
				ctrl_o   = '{ALU_BNE, SEL_JUMP, '0, 1'b0};
				rd_en0   = 1'b1;
				rd_en1   = 1'b1;
				branch_o = BR_BNE;
			end
			default: begin
			end
		endcase
	end

	// register file index always taken from rs and rt
	assign op0_o.rd_en = rd_en0;
	assign op0_o.addr  = rs;
	assign op0_o.imm   = imm;
	assign op1_o.rd_en = rd_en1;
	assign op1_o.addr  = rt;
	assign op1_o.imm   = imm;

endmodule

`default_nettype wire

// File: rtl/operand_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch
	import decode_pkg::*;
(
	input  aluop_t   ex_aluop_i,
	input  bypass_t  ex_i,
	input  bypass_t  mem_i,
	input  word_t    rf_data_i,
	operand_if.fetch op
);

	logic ex_hit;
	logic mem_hit;
	logic ex_is_load;

	assign ex_is_load = (ex_aluop_i == ALU_LW);  // LW is the only load
	assign ex_hit     = ex_i.wreg && (ex_i.wd == op.addr);
	assign mem_hit    = mem_i.wreg && (mem_i.wd == op.addr);

	// load data only exists after mem, so wait a cycle
	assign op.stall = op.rd_en && ex_is_load && (ex_i.wd == op.addr);

	always_comb begin
		if (!op.rd_en) begin
			op.value = op.imm;
		end else if (ex_hit) begin
			op.value = ex_i.wdata;  // youngest result wins
		end else if (mem_hit) begin
			op.value = mem_i.wdata;
		end else begin
			op.value = rf_data_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit
	import decode_pkg::*;
(
	input  word_t    pc_i,
	input  word_t    inst_i,
	input  branch_t  branch_i,
	operand_if.user  op0_i,
	operand_if.user  op1_i,
	output logic     branch_flag_o,
	output word_t    branch_target_o,
	output word_t    link_addr_o,
	output logic     next_inst_in_delayslot_o
);

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t jump_target;
	word_t branch_offset;
	logic  taken;

	assign pc_plus_4     = pc_i + 32'd4;
	assign pc_plus_8     = pc_i + 32'd8;
	assign jump_target   = {pc_plus_4[31:28], inst_i[25:0], 2'b00};
	assign branch_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	always_comb begin
		taken           = 1'b0;
		branch_target_o = '0;
		link_addr_o     = '0;
		case (branch_i)
			BR_J: begin
				taken           = 1'b1;
				branch_target_o = jump_target;
			end
			BR_JAL: begin
				taken           = 1'b1;
				branch_target_o = jump_target;
				link_addr_o     = pc_plus_8;  // skip the delay slot
			end
			BR_JR: begin
				taken           = 1'b1;
				branch_target_o = op0_i.value;
			end
			BR_JALR: begin
				taken           = 1'b1;
				branch_target_o = op0_i.value;
				link_addr_o     = pc_plus_8;
			end
			BR_BEQ: begin
				taken = (op0_i.value == op1_i.value);
				if (taken) begin
					branch_target_o = pc_plus_4 + branch_offset;
				end
			end
			BR_BNE: begin
				taken = (op0_i.value != op1_i.value);
				if (taken) begin
					branch_target_o = pc_plus_4 + branch_offset;
				end
			end
			default: begin
			end
		endcase
	end

	assign branch_flag_o            = taken;
	assign next_inst_in_delayslot_o = taken;  // next fetch is the slot

endmodule

`default_nettype wire

// File: rtl/id_ex_reg.sv
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg
	import decode_pkg::*;
(
	input  logic    clk,
	input  logic    rst_i,
	input  ctrl_t   ctrl_i,
	operand_if.user op0_i,
	operand_if.user op1_i,
	input  word_t   link_addr_i,
	input  logic    in_delayslot_i,
	input  word_t   inst_i,
	output logic    stall_o,
	output ctrl_t   ex_ctrl_o,
	output word_t   ex_reg1_o,
	output word_t   ex_reg2_o,
	output word_t   ex_link_addr_o,
	output word_t   ex_inst_o,
	output logic    ex_in_delayslot_o
);

	assign stall_o = op0_i.stall | op1_i.stall;

	always_ff @(posedge clk) begin
		if (rst_i || stall_o) begin
			// bubble into execute
			ex_ctrl_o         <= CTRL_BUBBLE;
			ex_reg1_o         <= '0;
			ex_reg2_o         <= '0;
			ex_link_addr_o    <= '0;
			ex_inst_o         <= '0;
			ex_in_delayslot_o <= 1'b0;
		end else begin
			ex_ctrl_o         <= ctrl_i;
			ex_reg1_o         <= op0_i.value;
			ex_reg2_o         <= op1_i.value;
			ex_link_addr_o    <= link_addr_i;
			ex_inst_o         <= inst_i;  // execute needs the offset for lw/sw
			ex_in_delayslot_o <= in_delayslot_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage
	import decode_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  logic      is_in_delayslot_i,
	input  word_t     reg1_data_i,
	input  word_t     reg2_data_i,
	input  aluop_t    ex_aluop_i,
	input  logic      ex_wreg_i,
	input  reg_addr_t ex_wd_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_wreg_i,
	input  reg_addr_t mem_wd_i,
	input  word_t     mem_wdata_i,
	output logic      reg1_read_o,
	output logic      reg2_read_o,
	output reg_addr_t reg1_addr_o,
	output reg_addr_t reg2_addr_o,
	output logic      stall_o,
	output logic      branch_flag_o,
	output word_t     branch_target_o,
	output logic      next_inst_in_delayslot_o,
	output aluop_t    ex_aluop_o,
	output alusel_t   ex_alusel_o,
	output reg_addr_t ex_wd_o,
	output logic      ex_wreg_o,
	output word_t     ex_reg1_o,
	output word_t     ex_reg2_o,
	output word_t     ex_link_addr_o,
	output word_t     ex_inst_o,
	output logic      ex_in_delayslot_o
);

	ctrl_t   dec_ctrl;
	branch_t dec_branch;
	ctrl_t   ex_ctrl;
	word_t   link_addr;
	bypass_t ex_bypass;
	bypass_t mem_bypass;
	word_t   rf_data [2];

	operand_if op_if [2] ();  // 0 is rs, 1 is rt

	assign ex_bypass  = '{wreg: ex_wreg_i, wd: ex_wd_i, wdata: ex_wdata_i};
	assign mem_bypass = '{wreg: mem_wreg_i, wd: mem_wd_i, wdata: mem_wdata_i};
	assign rf_data[0] = reg1_data_i;
	assign rf_data[1] = reg2_data_i;

	inst_decoder u_decoder (
		.inst_i   (inst_i),
		.ctrl_o   (dec_ctrl),
		.branch_o (dec_branch),
		.op0_o    (op_if[0]),
		.op1_o    (op_if[1])
	);

	for (genvar g = 0; g < 2; g++) begin : g_fetch
		operand_fetch u_fetch (
			.ex_aluop_i (ex_aluop_i),
			.ex_i       (ex_bypass),
			.mem_i      (mem_bypass),
			.rf_data_i  (rf_data[g]),
			.op         (op_if[g])
		);
	end

	branch_unit u_branch (
		.pc_i                     (pc_i),
		.inst_i                   (inst_i),
		.branch_i                 (dec_branch),
		.op0_i                    (op_if[0]),
		.op1_i                    (op_if[1]),
		.branch_flag_o            (branch_flag_o),
		.branch_target_o          (branch_target_o),
		.link_addr_o              (link_addr),
		.next_inst_in_delayslot_o (next_inst_in_delayslot_o)
	);

	id_ex_reg u_id_ex (
		.clk               (clk),
		.rst_i             (rst_i),
		.ctrl_i            (dec_ctrl),
		.op0_i             (op_if[0]),
		.op1_i             (op_if[1]),
		.link_addr_i       (link_addr),
		.in_delayslot_i    (is_in_delayslot_i),
		.inst_i            (inst_i),
		.stall_o           (stall_o),
		.ex_ctrl_o         (ex_ctrl),
		.ex_reg1_o         (ex_reg1_o),
		.ex_reg2_o         (ex_reg2_o),
		.ex_link_addr_o    (ex_link_addr_o),
		.ex_inst_o         (ex_inst_o),
		.ex_in_delayslot_o (ex_in_delayslot_o)
	);

	// register file read port
	assign reg1_read_o = op_if[0].rd_en;
	assign reg1_addr_o = op_if[0].addr;
	assign reg2_read_o = op_if[1].rd_en;
	assign reg2_addr_o = op_if[1].addr;

	assign ex_aluop_o  = ex_ctrl.aluop;
	assign ex_alusel_o = ex_ctrl.alusel;
	assign ex_wd_o     = ex_ctrl.wd;
	assign ex_wreg_o   = ex_ctrl.wreg;

endmodule

`default_nettype wire

// File: verification/decode_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module decode_stage_tb
	import decode_pkg::*;
();

	localparam word_t PC0      = 32'h0040_0100;
	localparam int    WAIT_MAX = 20;

	// stimulus first, then the expected ex_ bundle and read requests
	typedef struct packed {
		word_t      inst;
		word_t      pc;
		logic       dly;
		logic [2:0] fwd;  // 0 none, 1 mem hit, 2 ex and mem hit, 3 lw in ex, 4 other regs
		logic       eq;   // rt data copies rs data
		aluop_t     aluop;
		alusel_t    alusel;
		reg_addr_t  wd;
		logic       wreg;
		logic       rd1;
		logic       rd2;
		word_t      imm;  // operand value when not read
	} row_t;

	logic      clk;
	logic      rst_i;
	word_t     pc_i;
	word_t     inst_i;
	logic      is_in_delayslot_i;
	word_t     reg1_data_i;
	word_t     reg2_data_i;
	aluop_t    ex_aluop_i;
	logic      ex_wreg_i;
	reg_addr_t ex_wd_i;
	word_t     ex_wdata_i;
	logic      mem_wreg_i;
	reg_addr_t mem_wd_i;
	word_t     mem_wdata_i;
	logic      reg1_read_o;
	logic      reg2_read_o;
	reg_addr_t reg1_addr_o;
	reg_addr_t reg2_addr_o;
	logic      stall_o;
	logic      branch_flag_o;
	word_t     branch_target_o;
	logic      next_inst_in_delayslot_o;
	aluop_t    ex_aluop_o;
	alusel_t   ex_alusel_o;
	reg_addr_t ex_wd_o;
	logic      ex_wreg_o;
	word_t     ex_reg1_o;
	word_t     ex_reg2_o;
	word_t     ex_link_addr_o;
	word_t     ex_inst_o;
	logic      ex_in_delayslot_o;

	row_t        rows [$];
	logic [31:0] lfsr_state = 32'd3;
	int          errors = 0;
	word_t       exp_op0;
	word_t       exp_op1;

	decode_stage i_decode_stage (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return bits;
	endfunction

	function automatic word_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
			input reg_addr_t rd, input logic [4:0] sh, input logic [5:0] fn);
		return {`MIPS_OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
			input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// execute beats memory beats register file
	function automatic word_t expect_operand(input logic rd, input reg_addr_t addr,
			input word_t rf, input word_t imm);
		if (!rd)
			return imm;
		if (ex_wreg_i && ex_wd_i == addr)
			return ex_wdata_i;
		if (mem_wreg_i && mem_wd_i == addr)
			return mem_wdata_i;
		return rf;
	endfunction

	task automatic compare_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic build_table();
		rows.push_back('{enc_i(`MIPS_OP_ORI, 5'd1, 5'd2, 16'h8001), PC0, '0, 3'd0, '0,
			ALU_OR, SEL_LOGIC, 5'd2, '1, '1, '0, 32'h0000_8001});
		rows.push_back('{enc_i(`MIPS_OP_ANDI, 5'd4, 5'd3, 16'hF0F0), PC0, '0, 3'd1, '0,
			ALU_AND, SEL_LOGIC, 5'd3, '1, '1, '0, 32'h0000_F0F0});
		rows.push_back('{enc_i(`MIPS_OP_XORI, 5'd6, 5'd5, 16'h1234), PC0, '0, 3'd2, '0,
			ALU_XOR, SEL_LOGIC, 5'd5, '1, '1, '0, 32'h0000_1234});
		rows.push_back('{enc_i(`MIPS_OP_LUI, 5'd0, 5'd7, 16'hBEEF), PC0, '0, 3'd0, '0,
			ALU_OR, SEL_LOGIC, 5'd7, '1, '1, '0, 32'hBEEF_0000});
		rows.push_back('{enc_i(`MIPS_OP_ADDIU, 5'd9, 5'd8, 16'hFFF0), PC0, '0, 3'd4, '0,
			ALU_ADDIU, SEL_ARITH, 5'd8, '1, '1, '0, 32'hFFFF_FFF0});
		rows.push_back('{enc_r(5'd0, 5'd11, 5'd10, 5'd5, `MIPS_FN_SLL), PC0, '0, 3'd0, '0,
			ALU_SLL, SEL_SHIFT, 5'd10, '1, '0, '1, 32'd5});
		rows.push_back('{enc_r(5'd0, 5'd13, 5'd12, 5'd31, `MIPS_FN_SRL), PC0, '0, 3'd0, '0,
			ALU_SRL, SEL_SHIFT, 5'd12, '1, '0, '1, 32'd31});
		rows.push_back('{enc_r(5'd0, 5'd15, 5'd14, 5'd1, `MIPS_FN_SRA), PC0, '1, 3'd0, '0,
			ALU_SRA, SEL_SHIFT, 5'd14, '1, '0, '1, 32'd1});
		rows.push_back('{enc_r(5'd17, 5'd18, 5'd16, 5'd0, `MIPS_FN_ADDU), PC0, '0, 3'd2, '0,
			ALU_ADDU, SEL_ARITH, 5'd16, '1, '1, '1, 32'd0});
		rows.push_back('{enc_r(5'd20, 5'd21, 5'd19, 5'd0, `MIPS_FN_SUBU), PC0, '0, 3'd0, '0,
			ALU_SUBU, SEL_ARITH, 5'd19, '1, '1, '1, 32'd0});
		rows.push_back('{enc_r(5'd23, 5'd24, 5'd22, 5'd0, `MIPS_FN_SLT), PC0, '0, 3'd4, '0,
			ALU_SLT, SEL_ARITH, 5'd22, '1, '1, '1, 32'd0});
		rows.push_back('{enc_r(5'd26, 5'd27, 5'd25, 5'd0, `MIPS_FN_SLTU), PC0, '0, 3'd1, '0,
			ALU_SLTU, SEL_ARITH, 5'd25, '1, '1, '1, 32'd0});
		rows.push_back('{enc_r(5'd2, 5'd3, 5'd1, 5'd0, `MIPS_FN_OR), PC0, '0, 3'd0, '0,
			ALU_OR, SEL_LOGIC, 5'd1, '1, '1, '1, 32'd0});
		rows.push_back('{enc_r(5'd5, 5'd6, 5'd4, 5'd0, `MIPS_FN_AND), PC0, '0, 3'd2, '0,
			ALU_AND, SEL_LOGIC, 5'd4, '1, '1, '1, 32'd0});
		rows.push_back('{enc_r(5'd8, 5'd9, 5'd7, 5'd0, `MIPS_FN_XOR), PC0, '0, 3'd0, '0,
			ALU_XOR, SEL_LOGIC, 5'd7, '1, '1, '1, 32'd0});
		rows.push_back('{enc_r(5'd11, 5'd12, 5'd10, 5'd0, `MIPS_FN_NOR), PC0, '1, 3'd1, '0,
			ALU_NOR, SEL_LOGIC, 5'd10, '1, '1, '1, 32'd0});
		rows.push_back('{enc_i(`MIPS_OP_SW, 5'd14, 5'd13, 16'h0010), PC0, '0, 3'd0, '0,
			ALU_SW, SEL_LOADSTORE, 5'd13, '0, '1, '1, 32'd0});
		// load-use on rs, ex bundle must be the bubble
		rows.push_back('{enc_r(5'd4, 5'd5, 5'd3, 5'd0, `MIPS_FN_ADDU), PC0, '1, 3'd3, '0,
			ALU_NOP, SEL_NOP, 5'd0, '0, '1, '1, 32'd0});
		rows.push_back('{{`MIPS_OP_J, 26'h012_3456}, 32'h9000_0200, '0, 3'd0, '0,
			ALU_J, SEL_JUMP, 5'd0, '0, '0, '0, 32'd0});
		rows.push_back('{{`MIPS_OP_JAL, 26'h3FF_FFFF}, 32'h1FFF_FFFC, '0, 3'd0, '0,
			ALU_JAL, SEL_JUMP, 5'd31, '1, '0, '0, 32'd0});  // pc+4 crosses a region
		rows.push_back('{enc_r(5'd5, 5'd0, 5'd0, 5'd0, `MIPS_FN_JR), PC0, '0, 3'd1, '0,
			ALU_JR, SEL_JUMP, 5'd0, '0, '1, '0, 32'd0});
		rows.push_back('{enc_r(5'd6, 5'd0, 5'd31, 5'd0, `MIPS_FN_JALR), 32'h0040_0010, '0, 3'd0,
			'0, ALU_JALR, SEL_JUMP, 5'd31, '1, '1, '0, 32'd0});
		rows.push_back('{enc_i(`MIPS_OP_BEQ, 5'd7, 5'd8, 16'h0004), 32'h0040_0020, '0, 3'd0, '1,
			ALU_BEQ, SEL_JUMP, 5'd0, '0, '1, '1, 32'd0});
		rows.push_back('{enc_i(`MIPS_OP_BEQ, 5'd9, 5'd10, 16'hFFFC), 32'h0040_0030, '0, 3'd0, '0,
			ALU_BEQ, SEL_JUMP, 5'd0, '0, '1, '1, 32'd0});
		rows.push_back('{enc_i(`MIPS_OP_BNE, 5'd11, 5'd12, 16'hFFF8), 32'h0040_1000, '0, 3'd0,
			'0, ALU_BNE, SEL_JUMP, 5'd0, '0, '1, '1, 32'd0});
		rows.push_back('{enc_i(`MIPS_OP_BNE, 5'd13, 5'd14, 16'h0100), 32'h0040_2000, '0, 3'd0,
			'1, ALU_BNE, SEL_JUMP, 5'd0, '0, '1, '1, 32'd0});
	endtask

	task automatic drive_row(input row_t r);
		reg_addr_t rs;
		rs                = r.inst[25:21];
		pc_i              = r.pc;
		inst_i            = r.inst;
		is_in_delayslot_i = r.dly;
		reg1_data_i       = draw_bits(32);
		reg2_data_i       = r.eq ? reg1_data_i : draw_bits(32);
		ex_wdata_i        = draw_bits(32);
		mem_wdata_i       = draw_bits(32);
		ex_aluop_i        = (r.fwd == 3'd3) ? ALU_LW : ALU_ADDU;
		ex_wreg_i         = (r.fwd == 3'd2 || r.fwd == 3'd3 || r.fwd == 3'd4);
		ex_wd_i           = (r.fwd == 3'd4) ? (rs ^ 5'd1) : rs;
		mem_wreg_i        = (r.fwd == 3'd1 || r.fwd == 3'd2 || r.fwd == 3'd4);
		mem_wd_i          = ex_wd_i;
		exp_op0 = expect_operand(r.rd1, rs, reg1_data_i, r.imm);
		exp_op1 = expect_operand(r.rd2, r.inst[20:16], reg2_data_i, r.imm);
	endtask

	task automatic check_comb(input row_t r);
		word_t pc4;
		word_t target;
		logic  flag;
		pc4    = r.pc + 32'd4;
		target = pc4 + {{14{r.inst[15]}}, r.inst[15:0], 2'b00};
		case (r.aluop)
			ALU_J, ALU_JAL: begin
				flag   = 1'b1;
				target = {pc4[31:28], r.inst[25:0], 2'b00};
			end
			ALU_JR, ALU_JALR: begin
				flag   = 1'b1;
				target = exp_op0;
			end
			ALU_BEQ: flag = (exp_op0 == exp_op1);
			ALU_BNE: flag = (exp_op0 != exp_op1);
			default: flag = 1'b0;
		endcase
		compare_value("reg1_read_o", 32'(reg1_read_o), 32'(r.rd1));
		compare_value("reg2_read_o", 32'(reg2_read_o), 32'(r.rd2));
		compare_value("reg1_addr_o", 32'(reg1_addr_o), 32'(r.inst[25:21]));
		compare_value("reg2_addr_o", 32'(reg2_addr_o), 32'(r.inst[20:16]));
		compare_value("stall_o", 32'(stall_o), 32'(r.fwd == 3'd3));
		compare_value("branch_flag_o", 32'(branch_flag_o), 32'(flag));
		compare_value("next_inst_in_delayslot_o", 32'(next_inst_in_delayslot_o), 32'(flag));
		if (flag)
			compare_value("branch_target_o", branch_target_o, target);
	endtask

	task automatic check_regs(input row_t r);
		logic  bubble;
		word_t link;
		bubble = (r.fwd == 3'd3);
		link   = (r.aluop == ALU_JAL || r.aluop == ALU_JALR) ? r.pc + 32'd8 : '0;
		compare_value("ex_aluop_o", 32'(ex_aluop_o), 32'(r.aluop));
		compare_value("ex_alusel_o", 32'(ex_alusel_o), 32'(r.alusel));
		compare_value("ex_wd_o", 32'(ex_wd_o), 32'(r.wd));
		compare_value("ex_wreg_o", 32'(ex_wreg_o), 32'(r.wreg));
		compare_value("ex_reg1_o", ex_reg1_o, bubble ? '0 : exp_op0);
		compare_value("ex_reg2_o", ex_reg2_o, bubble ? '0 : exp_op1);
		compare_value("ex_link_addr_o", ex_link_addr_o, link);
		compare_value("ex_inst_o", ex_inst_o, bubble ? '0 : r.inst);
		compare_value("ex_in_delayslot_o", 32'(ex_in_delayslot_o), 32'(r.dly && !bubble));
	endtask

	task automatic wait_for_bubble(output logic ok);
		int n;
		n = 0;
		while (!(ex_aluop_o == ALU_NOP && !ex_wreg_o && !stall_o) && n < WAIT_MAX) begin
			@(posedge clk);
			#1;
			n++;
		end
		ok = (ex_aluop_o == ALU_NOP && !ex_wreg_o && !stall_o);
	endtask

	initial begin
		logic ok;
		rst_i             = 1'b1;
		pc_i              = '0;
		inst_i            = enc_i(`MIPS_OP_ORI, 5'd1, 5'd2, 16'h1234);  // writes $2 unless reset
		is_in_delayslot_i = 1'b0;
		reg1_data_i       = '0;
		reg2_data_i       = '0;
		ex_aluop_i        = ALU_NOP;
		ex_wreg_i         = 1'b0;
		ex_wd_i           = '0;
		ex_wdata_i        = '0;
		mem_wreg_i        = 1'b0;
		mem_wd_i          = '0;
		mem_wdata_i       = '0;
		build_table();
		repeat (16) @(posedge clk);
		#1;
		rst_i = 1'b0;
		wait_for_bubble(ok);
		assert (ok) else begin
			$display("timeout: ex bundle never showed a bubble after reset");
			errors++;
		end
		if (ok) begin
			compare_value("ex_wd_o", 32'(ex_wd_o), 32'd0);
			compare_value("ex_reg1_o", ex_reg1_o, '0);
			compare_value("ex_link_addr_o", ex_link_addr_o, '0);
			compare_value("ex_in_delayslot_o", 32'(ex_in_delayslot_o), 32'd0);
			foreach (rows[i]) begin
				drive_row(rows[i]);
				@(negedge clk);
				check_comb(rows[i]);
				@(posedge clk);
				#1;
				check_regs(rows[i]);
			end
		end
		$display("rows: %0d, errors: %0d", rows.size(), errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/operand_if.sv
rtl/inst_decoder.sv
rtl/operand_fetch.sv
rtl/branch_unit.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
verification/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module decode_stage_tb -f sources.f \
	-o sim_decode > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_decode > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
